// ==== src/sica_defs.svh ====
`ifndef SICA_DEFS_SVH
`define SICA_DEFS_SVH

// Sample and vector geometry
`define DATA_WIDTH 16
`define DIM 5

// CORDIC datapath
`define CORDIC_WIDTH 22
`define CORDIC_STAGES 16

// Convergence rules
`define THRESHOLD 32
`define MAX_ITERATIONS 8

`endif

// ==== src/sica_types_pkg.sv ====
`include "sica_defs.svh"

package sica_types_pkg;

    // One serial weight sample
    typedef logic signed [`DATA_WIDTH-1:0] sample_t;

    // Wider word inside the CORDIC to absorb growth
    typedef logic signed [`CORDIC_WIDTH-1:0] cordic_word_t;

    // Element 0 sits in the lowest slot
    typedef sample_t [`DIM-1:0] w_vec_t;

    typedef logic [$clog2(`DIM)-1:0] elem_idx_t;

endpackage

// ==== src/sica_ctrl_pkg.sv ====
`include "sica_defs.svh"

package sica_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_NEW,
        LOAD_OLD,
        MEASURE,
        WAIT
    } buf_state_t;

    typedef logic [$clog2(`MAX_ITERATIONS+1)-1:0] iter_count_t;

endpackage

// ==== src/cordic_if.sv ====
`timescale 1ns/1ps

interface cordic_if;
    import sica_types_pkg::*;

    // Request side
    logic         en;
    cordic_word_t xin;
    cordic_word_t yin;

    // Result side, one pulse per request
    logic         opvld;
    cordic_word_t xout;

    modport requester (output en, xin, yin, input opvld, xout);
    modport core (input en, xin, yin, output opvld, xout);

endinterface

// ==== src/cordic_vec.sv ====
`timescale 1ns/1ps
`include "sica_defs.svh"

module cordic_vec (
    input logic    clk,
    input logic    nreset,
    cordic_if.core cif
);
    import sica_types_pkg::*;

    localparam int STAGE_W = $clog2(`CORDIC_STAGES);

    logic               busy;
    logic               comp;
    logic [STAGE_W-1:0] stage;
    cordic_word_t       x;
    cordic_word_t       y;

    // Sequencing of load, micro-rotations and gain compensation
    always_ff @(posedge clk) begin
        if (!nreset) begin
            busy      <= 1'b0;
            comp      <= 1'b0;
            stage     <= '0;
            cif.opvld <= 1'b0;
        end else begin
            cif.opvld <= 1'b0;
            if (!busy) begin
                if (cif.en) begin
                    busy  <= 1'b1;
                    stage <= '0;
                end
            end else if (!comp) begin
                stage <= stage + 1'b1;
                if (stage == STAGE_W'(`CORDIC_STAGES - 1)) begin
                    comp <= 1'b1;
                end
            end else begin
                comp      <= 1'b0;
                busy      <= 1'b0;
                cif.opvld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && cif.en) begin
            // Fold into the right half plane first
            x <= cif.xin[`CORDIC_WIDTH-1] ? -cif.xin : cif.xin;
            y <= cif.yin;
        end else if (busy && !comp) begin
            // Drive y toward zero
            if (!y[`CORDIC_WIDTH-1]) begin
                x <= x + (y >>> stage);
                y <= y - (x >>> stage);
            end else begin
                x <= x - (y >>> stage);
                y <= y + (x >>> stage);
            end
        end else if (comp) begin
            // Gain of about 0.6074 from four shifted terms
            cif.xout <= (x >>> 1) + (x >>> 3) - (x >>> 6) - (x >>> 9);
        end
    end

    // Requester must wait for opvld before the next call
    assert property (@(posedge clk) disable iff (!nreset) cif.en |-> !busy)
        else $error("cordic_vec: request while busy");

endmodule

// ==== src/mag_chain.sv ====
`timescale 1ns/1ps
`include "sica_defs.svh"

module mag_chain (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    start,
    input  sica_types_pkg::w_vec_t  vec,
    output sica_types_pkg::sample_t norm,
    output logic                    done,
    cordic_if.requester             cif
);
    import sica_types_pkg::*;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_ISSUE,
        CH_WAIT
    } chain_state_t;

    localparam cordic_word_t SAT_MAX = cordic_word_t'((1 << (`DATA_WIDTH - 1)) - 1);
    localparam cordic_word_t SAT_MIN = -SAT_MAX - 1;

    chain_state_t state;
    elem_idx_t    idx;
    cordic_word_t acc;

    function automatic sample_t saturate(input cordic_word_t v);
        if (v > SAT_MAX)
            return sample_t'(SAT_MAX);
        else if (v < SAT_MIN)
            return sample_t'(SAT_MIN);
        else
            return sample_t'(v);
    endfunction

    // Running norm against the next element
    assign cif.en  = (state == CH_ISSUE);
    assign cif.xin = acc;
    assign cif.yin = cordic_word_t'(vec[idx]);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= CH_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                CH_IDLE: begin
                    if (start) begin
                        idx   <= elem_idx_t'(1);
                        state <= CH_ISSUE;
                    end
                end
                CH_ISSUE: begin
                    state <= CH_WAIT;
                end
                CH_WAIT: begin
                    if (cif.opvld) begin
                        if (idx == elem_idx_t'(`DIM - 1)) begin
                            done  <= 1'b1;
                            state <= CH_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= CH_ISSUE;
                        end
                    end
                end
                default: state <= CH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CH_IDLE && start) begin
            acc <= cordic_word_t'(vec[0]);
        end else if (state == CH_WAIT && cif.opvld) begin
            acc <= cif.xout;
            if (idx == elem_idx_t'(`DIM - 1)) begin
                norm <= saturate(cif.xout);
            end
        end
    end

    assert property (@(posedge clk) disable iff (!nreset) cif.opvld |-> state == CH_WAIT)
        else $error("mag_chain: result without an outstanding call");

endmodule

// ==== src/w_buffer.sv ====
`timescale 1ns/1ps
`include "sica_defs.svh"

module w_buffer (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    start,
    input  sica_types_pkg::sample_t serial_w_in,
    input  logic                    serial_w_valid,
    input  logic                    chain_done,
    output logic                    measure,
    output sica_types_pkg::w_vec_t  w_new,
    output sica_types_pkg::w_vec_t  w_diff
);
    import sica_types_pkg::*;
    import sica_ctrl_pkg::*;

    localparam elem_idx_t LAST_ELEM = elem_idx_t'(`DIM - 1);

    buf_state_t state;
    elem_idx_t  load_cnt;
    w_vec_t     w_old;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state    <= IDLE;
            load_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        load_cnt <= '0;
                        state    <= LOAD_NEW;
                    end
                end
                LOAD_NEW: begin
                    if (serial_w_valid) begin
                        if (load_cnt == LAST_ELEM) begin
                            load_cnt <= '0;
                            state    <= LOAD_OLD;
                        end else begin
                            load_cnt <= load_cnt + 1'b1;
                        end
                    end
                end
                LOAD_OLD: begin
                    if (serial_w_valid) begin
                        if (load_cnt == LAST_ELEM) begin
                            load_cnt <= '0;
                            state    <= MEASURE;
                        end else begin
                            load_cnt <= load_cnt + 1'b1;
                        end
                    end
                end
                MEASURE: state <= WAIT;
                WAIT: begin
                    if (chain_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Samples enter at the top so element 0 ends up in slot 0
    always_ff @(posedge clk) begin
        if (state == LOAD_NEW && serial_w_valid) begin
            w_new <= {serial_w_in, w_new[`DIM-1:1]};
        end
        if (state == LOAD_OLD && serial_w_valid) begin
            w_old <= {serial_w_in, w_old[`DIM-1:1]};
        end
    end

    assign measure = (state == MEASURE);

    // New minus old clipped back to sample range
    always_comb begin
        logic signed [`DATA_WIDTH:0] d;
        d = '0;
        for (int i = 0; i < `DIM; i++) begin
            d = w_new[i] - w_old[i];
            if (d[`DATA_WIDTH] != d[`DATA_WIDTH-1])
                w_diff[i] = d[`DATA_WIDTH] ? {1'b1, {(`DATA_WIDTH-1){1'b0}}}
                                           : {1'b0, {(`DATA_WIDTH-1){1'b1}}};
            else
                w_diff[i] = d[`DATA_WIDTH-1:0];
        end
    end

    // Chains report back only while a measurement is outstanding
    assert property (@(posedge clk) disable iff (!nreset) chain_done |-> state == WAIT)
        else $error("w_buffer: chain done outside a measurement");

endmodule

// ==== src/conv_judge.sv ====
`timescale 1ns/1ps
`include "sica_defs.svh"

module conv_judge (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    new_done,
    input  sica_types_pkg::sample_t new_norm,
    input  logic                    diff_done,
    input  sica_types_pkg::sample_t diff_norm_in,
    output logic                    done,
    output sica_types_pkg::sample_t w_norm,
    output sica_types_pkg::sample_t diff_norm,
    output logic                    converged,
    output logic                    limit_reached
);
    import sica_types_pkg::*;
    import sica_ctrl_pkg::*;

    logic        have_new;
    logic        have_diff;
    sample_t     new_q;
    sample_t     diff_q;
    iter_count_t iter_cnt;
    logic        both_in;
    logic        pass;
    sample_t     new_val;
    sample_t     diff_val;

    // A result arriving this cycle counts as already in
    assign both_in  = (have_new | new_done) & (have_diff | diff_done);
    assign new_val  = new_done ? new_norm : new_q;
    assign diff_val = diff_done ? diff_norm_in : diff_q;
    assign pass     = (diff_val <= sample_t'(`THRESHOLD));

    assign limit_reached = (iter_cnt == iter_count_t'(`MAX_ITERATIONS));

    always_ff @(posedge clk) begin
        if (!nreset) begin
            have_new  <= 1'b0;
            have_diff <= 1'b0;
            done      <= 1'b0;
            converged <= 1'b0;
            iter_cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (both_in) begin
                have_new  <= 1'b0;
                have_diff <= 1'b0;
                done      <= 1'b1;
                converged <= pass;
                // Consecutive misses, held at the limit
                if (pass)
                    iter_cnt <= '0;
                else if (!limit_reached)
                    iter_cnt <= iter_cnt + 1'b1;
            end else begin
                if (new_done)
                    have_new <= 1'b1;
                if (diff_done)
                    have_diff <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_done)
            new_q <= new_norm;
        if (diff_done)
            diff_q <= diff_norm_in;
        if (both_in) begin
            w_norm    <= new_val;
            diff_norm <= diff_val;
        end
    end

endmodule

// ==== src/sica_top.sv ====
`timescale 1ns/1ps

module sica_top (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    start,
    input  sica_types_pkg::sample_t serial_w_in,
    input  logic                    serial_w_valid,
    output logic                    done,
    output logic                    converged,
    output logic                    limit_reached,
    output sica_types_pkg::sample_t w_norm,
    output sica_types_pkg::sample_t diff_norm
);
    import sica_types_pkg::*;

    logic    measure;
    w_vec_t  w_new;
    w_vec_t  w_diff;
    logic    new_done;
    logic    diff_done;
    sample_t new_norm;
    sample_t diff_norm_raw;

    cordic_if new_cif ();
    cordic_if diff_cif ();

    w_buffer w_buffer_i (
        .clk            (clk),
        .nreset         (nreset),
        .start          (start),
        .serial_w_in    (serial_w_in),
        .serial_w_valid (serial_w_valid),
        .chain_done     (done),
        .measure        (measure),
        .w_new          (w_new),
        .w_diff         (w_diff)
    );

    // Norm of the new estimate
    mag_chain new_chain_i (
        .clk    (clk),
        .nreset (nreset),
        .start  (measure),
        .vec    (w_new),
        .norm   (new_norm),
        .done   (new_done),
        .cif    (new_cif.requester)
    );

    cordic_vec new_cordic_i (
        .clk    (clk),
        .nreset (nreset),
        .cif    (new_cif.core)
    );

    // Norm of the step between estimates
    mag_chain diff_chain_i (
        .clk    (clk),
        .nreset (nreset),
        .start  (measure),
        .vec    (w_diff),
        .norm   (diff_norm_raw),
        .done   (diff_done),
        .cif    (diff_cif.requester)
    );

    cordic_vec diff_cordic_i (
        .clk    (clk),
        .nreset (nreset),
        .cif    (diff_cif.core)
    );

    conv_judge conv_judge_i (
        .clk           (clk),
        .nreset        (nreset),
        .new_done      (new_done),
        .new_norm      (new_norm),
        .diff_done     (diff_done),
        .diff_norm_in  (diff_norm_raw),
        .done          (done),
        .w_norm        (w_norm),
        .diff_norm     (diff_norm),
        .converged     (converged),
        .limit_reached (limit_reached)
    );

endmodule

// ==== testbench/sica_tb.sv ====
`timescale 1ns/1ps
`include "sica_defs.svh"

module sica_tb;
    import sica_types_pkg::*;

    localparam int    NUM_RANDOM = 6;
    localparam string TRACE_FILE = "testbench/sica_trace.txt";

    logic    clk = 1'b0;
    logic    nreset;
    logic    start;
    sample_t serial_w_in;
    logic    serial_w_valid;
    logic    done;
    logic    converged;
    logic    limit_reached;
    sample_t w_norm;
    sample_t diff_norm;

    // Trace lines first, random pairs appended
    string  names[$];
    w_vec_t new_vecs[$];
    w_vec_t old_vecs[$];
    int     trace_conv[$];
    int     trace_limit[$];

    logic [31:0] lfsr = 32'h7a06;
    int          errors = 0;
    int          failed_tests = 0;
    int          done_count = 0;
    int          model_count = 0;
    logic        tests_ready = 1'b0;

    sica_top dut_i (
        .clk            (clk),
        .nreset         (nreset),
        .start          (start),
        .serial_w_in    (serial_w_in),
        .serial_w_valid (serial_w_valid),
        .done           (done),
        .converged      (converged),
        .limit_reached  (limit_reached),
        .w_norm         (w_norm),
        .diff_norm      (diff_norm)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (done === 1'b1)
            done_count++;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic sample_t clip_sample(input int v);
        if (v > 32767)
            return sample_t'(32767);
        else if (v < -32768)
            return sample_t'(-32768);
        return sample_t'(v);
    endfunction

    // One vectoring pass: magnitude of (xin, yin) after gain compensation
    function automatic cordic_word_t cordic_mag(input cordic_word_t xin, input cordic_word_t yin);
        cordic_word_t x;
        cordic_word_t y;
        cordic_word_t x_next;
        x = (xin < 0) ? -xin : xin;
        y = yin;
        for (int i = 0; i < `CORDIC_STAGES; i++) begin
            if (y >= 0) begin
                x_next = x + (y >>> i);
                y      = y - (x >>> i);
            end else begin
                x_next = x - (y >>> i);
                y      = y + (x >>> i);
            end
            x = x_next;
        end
        return (x >>> 1) + (x >>> 3) - (x >>> 6) - (x >>> 9);
    endfunction

    function automatic sample_t vector_norm(input w_vec_t v);
        cordic_word_t acc;
        acc = cordic_word_t'($signed(v[0]));
        for (int k = 1; k < `DIM; k++)
            acc = cordic_mag(acc, cordic_word_t'($signed(v[k])));
        return clip_sample(int'(acc));
    endfunction

    task automatic predict(input w_vec_t nv, input w_vec_t ov, output sample_t wn,
                           output sample_t dn, output int conv, output int lim);
        w_vec_t dv;
        for (int k = 0; k < `DIM; k++)
            dv[k] = clip_sample(int'($signed(nv[k])) - int'($signed(ov[k])));
        wn   = vector_norm(nv);
        dn   = vector_norm(dv);
        conv = (dn <= `THRESHOLD) ? 1 : 0;
        // Consecutive misses, held at the limit
        if (conv == 1)
            model_count = 0;
        else if (model_count < `MAX_ITERATIONS)
            model_count++;
        lim = (model_count == `MAX_ITERATIONS) ? 1 : 0;
    endtask

    task automatic check_value(input string sig, input logic signed [31:0] got,
                               input logic signed [31:0] expected);
        assert (got === expected)
        else begin
            $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, sig, got, expected);
            errors++;
        end
    endtask

    task automatic read_trace(output bit ok);
        int     fd;
        int     code;
        int     v;
        int     c;
        int     l;
        string  tok;
        string  rest;
        w_vec_t nv;
        w_vec_t ov;
        fd = $fopen(TRACE_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.getc(0) == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    for (int k = 0; k < `DIM; k++) begin
                        code = $fscanf(fd, "%d", v);
                        nv[k] = sample_t'(v);
                    end
                    for (int k = 0; k < `DIM; k++) begin
                        code = $fscanf(fd, "%d", v);
                        ov[k] = sample_t'(v);
                    end
                    code = $fscanf(fd, "%d %d", c, l);
                    names.push_back(tok);
                    new_vecs.push_back(nv);
                    old_vecs.push_back(ov);
                    trace_conv.push_back(c);
                    trace_limit.push_back(l);
                end
            end
            $fclose(fd);
        end
    endtask

    // Odd pairs differ by small noise so some of them converge
    task automatic add_random_tests;
        w_vec_t nv;
        w_vec_t ov;
        int     noise;
        for (int r = 0; r < NUM_RANDOM; r++) begin
            for (int k = 0; k < `DIM; k++)
                nv[k] = sample_t'(rand_bits(`DATA_WIDTH));
            for (int k = 0; k < `DIM; k++) begin
                if (r % 2 == 1) begin
                    noise = int'(rand_bits(5)) - 16;
                    ov[k] = clip_sample(int'($signed(nv[k])) + noise);
                end else begin
                    ov[k] = sample_t'(rand_bits(`DATA_WIDTH));
                end
            end
            names.push_back($sformatf("random_%0d", r));
            new_vecs.push_back(nv);
            old_vecs.push_back(ov);
            trace_conv.push_back(-1);
            trace_limit.push_back(-1);
        end
    endtask

    task automatic run_test(input int t);
        sample_t exp_wn;
        sample_t exp_dn;
        int      exp_conv;
        int      exp_lim;
        int      err_before;
        int      done_before;
        predict(new_vecs[t], old_vecs[t], exp_wn, exp_dn, exp_conv, exp_lim);
        err_before  = errors;
        done_before = done_count;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        for (int k = 0; k < 2 * `DIM; k++) begin
            serial_w_valid = 1'b1;
            serial_w_in    = (k < `DIM) ? new_vecs[t][k] : old_vecs[t][k - `DIM];
            @(posedge clk);
            #1;
        end
        serial_w_valid = 1'b0;
        // Stray strobes and starts while the chains run
        while (done !== 1'b1) begin
            if (t % 2 == 1) begin
                serial_w_in    = sample_t'(rand_bits(`DATA_WIDTH));
                serial_w_valid = (rand_bits(1) != 0);
                start          = (rand_bits(2) == 3);
            end
            @(posedge clk);
            #1;
        end
        start          = 1'b0;
        serial_w_valid = 1'b0;
        check_value("w_norm", w_norm, exp_wn);
        check_value("diff_norm", diff_norm, exp_dn);
        check_value("converged", converged, exp_conv);
        check_value("limit_reached", limit_reached, exp_lim);
        if (trace_conv[t] >= 0) begin
            check_value("converged (trace)", converged, trace_conv[t]);
            check_value("limit_reached (trace)", limit_reached, trace_limit[t]);
        end
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        check_value("done pulses", done_count - done_before, 1);
        check_value("w_norm held", w_norm, exp_wn);
        if (errors != err_before)
            failed_tests++;
        $display("%s: %s (w_norm %0d, diff_norm %0d, converged %0d, limit %0d)", names[t],
                 (errors == err_before) ? "ok" : "mismatch", w_norm, diff_norm,
                 converged, limit_reached);
    endtask

    initial begin
        bit ok;
        nreset         = 1'b0;
        start          = 1'b0;
        serial_w_in    = '0;
        serial_w_valid = 1'b0;
        read_trace(ok);
        if (!ok) begin
            $display("Cannot open the trace file %s", TRACE_FILE);
            errors++;
        end else begin
            add_random_tests();
            tests_ready = 1'b1;
            repeat (10) @(posedge clk);
            #1;
            nreset = 1'b1;
            check_value("done", done, 0);
            check_value("converged", converged, 0);
            check_value("limit_reached", limit_reached, 0);
            $display("reset: %s", (errors == 0) ? "ok" : "mismatch");
            for (int t = 0; t < names.size(); t++)
                run_test(t);
        end
        $display("Summary: %0d tests, %0d failing, %0d failed checks", names.size(),
                 failed_tests, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // Worst case per test: every CORDIC call twice over, plus loading
    initial begin
        int budget;
        wait (tests_ready);
        budget = names.size() * ((`DIM - 1) * (`CORDIC_STAGES + 4) * 2 + 2 * `DIM + 6) + 100;
        repeat (budget) @(posedge clk);
        $display("Timeout: no final result after %0d clock cycles", budget);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== testbench/sica_trace.txt ====
# name new[0] new[1] new[2] new[3] new[4] old[0] old[1] old[2] old[3] old[4] converged limit_reached
# signed decimal samples, element 0 first
equal_single 1000 0 0 0 0 1000 0 0 0 0 1 0
equal_mixed -300 1200 -45 7 -8000 -300 1200 -45 7 -8000 1 0
diff_at_thresh 500 -20 60 0 100 500 -20 60 0 68 1 0
diff_above_thresh 500 -20 60 0 100 500 -20 60 0 66 0 0
diff_below_thresh 500 -20 60 0 100 500 -20 60 0 74 1 0
neg_mixed -1200 -340 25 -7 900 1500 -2000 -25 77 -880 0 0
neg_all -100 -200 -300 -400 -500 100 200 300 400 500 0 0
sat_pos 30000 29000 -5 1 12345 -30000 -29000 5 -1 -12345 0 0
sat_neg -32768 -30000 0 0 0 32767 30000 0 0 0 0 0
max_elems 32767 32767 32767 32767 32767 0 0 0 0 0 0 0
min_elems -32768 -32768 -32768 -32768 -32768 0 0 0 0 0 0 0
one_big 0 0 0 0 20000 0 0 0 0 -20000 0 0
limit_hit 10 20 30 40 50 10 20 30 40 250 0 1
limit_held 70 70 70 70 70 -70 -70 -70 -70 -70 0 1
limit_clear 4321 -1234 555 -66 7 4321 -1234 555 -66 7 1 0
small_step 1000 1000 1000 1000 1000 1000 1000 1000 1000 990 1 0

// ==== all.f ====
+incdir+src
src/sica_types_pkg.sv
src/sica_ctrl_pkg.sv
src/cordic_if.sv
src/cordic_vec.sv
src/mag_chain.sv
src/w_buffer.sv
src/conv_judge.sv
src/sica_top.sv
testbench/sica_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= sica_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
